/* include/datapath_macros.svh */
`ifndef DATAPATH_MACROS_SVH
`define DATAPATH_MACROS_SVH

// Width of the shared bus and of every dedicated register
`define DATAPATH_WORD 32

// General registers R0 to R15
`define DATAPATH_REGS 16

// ALU opcode field
`define DATAPATH_OPW 5

`endif

/* src/datapathPkg.sv */
`include "datapath_macros.svh"

package datapathPkg;

    typedef logic [`DATAPATH_WORD-1:0] word_t;

    // Z high in the upper half, Z low in the lower half
    typedef logic [2*`DATAPATH_WORD-1:0] wide_t;

    typedef logic [`DATAPATH_REGS-1:0] regMask_t;

    typedef logic [$clog2(`DATAPATH_REGS)-1:0] regIndex_t;

    typedef enum logic [`DATAPATH_OPW-1:0] {
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opShr  = 5'd7,
        opShra = 5'd8,
        opShl  = 5'd9,
        opRor  = 5'd10,
        opRol  = 5'd11,
        opMul  = 5'd15,
        opDiv  = 5'd16,
        opNeg  = 5'd17,
        opNot  = 5'd18
    } aluOp_t;

    // Listed from highest to lowest bus priority
    typedef enum logic [2:0] {
        srcMdr,
        srcZlow,
        srcZhigh,
        srcPc,
        srcHi,
        srcLo,
        srcReg,
        srcNone
    } source_t;

endpackage

/* src/registerFile.sv */
`timescale 1ns/1ps
`include "datapath_macros.svh"

module registerFile (
    input  logic                  Clock,
    input  logic                  reset,
    input  datapathPkg::regMask_t regIn,
    input  datapathPkg::regMask_t regOut,
    input  datapathPkg::word_t    busData,
    output datapathPkg::word_t    regData,
    output logic                  regRequest
);

    datapathPkg::word_t     regs [`DATAPATH_REGS];
    datapathPkg::regIndex_t readIndex;

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < `DATAPATH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `DATAPATH_REGS; i++) begin
                if (regIn[i]) begin
                    regs[i] <= busData;
                end
            end
        end
    end

    // Scan downward so the lowest selected index is the one that sticks
    always_comb begin
        readIndex = '0;
        for (int i = `DATAPATH_REGS - 1; i >= 0; i--) begin
            if (regOut[i]) begin
                readIndex = datapathPkg::regIndex_t'(i);
            end
        end
    end

    assign regData    = regs[readIndex];
    assign regRequest = |regOut;

    // Control must never load two general registers from one bus word
    singleRegLoad: assert property (
        @(posedge Clock) disable iff (reset)
        $onehot0(regIn)
    ) else $error("regIn has more than one bit set: %h", regIn);

endmodule

/* src/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter (
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 PCout,
    input  logic                 Zhighout,
    input  logic                 Zlowout,
    input  logic                 MDRout,
    input  logic                 HIout,
    input  logic                 LOout,
    input  logic                 regRequest,
    input  datapathPkg::word_t   pcData,
    input  datapathPkg::word_t   zHigh,
    input  datapathPkg::word_t   zLow,
    input  datapathPkg::word_t   mdrData,
    input  datapathPkg::word_t   hiData,
    input  datapathPkg::word_t   loData,
    input  datapathPkg::word_t   regData,
    output datapathPkg::word_t   busData,
    output datapathPkg::source_t grant
);

    logic anyRequest;

    assign anyRequest = MDRout | Zlowout | Zhighout | PCout | HIout | LOout | regRequest;

    // Fixed priority, MDR first and general registers last
    always_comb begin
        if (MDRout) begin
            grant = datapathPkg::srcMdr;
        end else if (Zlowout) begin
            grant = datapathPkg::srcZlow;
        end else if (Zhighout) begin
            grant = datapathPkg::srcZhigh;
        end else if (PCout) begin
            grant = datapathPkg::srcPc;
        end else if (HIout) begin
            grant = datapathPkg::srcHi;
        end else if (LOout) begin
            grant = datapathPkg::srcLo;
        end else if (regRequest) begin
            grant = datapathPkg::srcReg;
        end else begin
            grant = datapathPkg::srcNone;
        end
    end

    always_comb begin
        case (grant)
            datapathPkg::srcMdr:   busData = mdrData;
            datapathPkg::srcZlow:  busData = zLow;
            datapathPkg::srcZhigh: busData = zHigh;
            datapathPkg::srcPc:    busData = pcData;
            datapathPkg::srcHi:    busData = hiData;
            datapathPkg::srcLo:    busData = loData;
            datapathPkg::srcReg:   busData = regData;
            default:               busData = '0;
        endcase
    end

    // An idle bus must read as no owner, and a request must always win an owner
    idleGrant: assert property (
        @(posedge Clock) disable iff (reset)
        (grant == datapathPkg::srcNone) == !anyRequest
    ) else $error("bus grant %s does not match request state", grant.name());

endmodule

/* src/alu.sv */
`timescale 1ns/1ps
`include "datapath_macros.svh"

module alu (
    input  logic                Clock,
    input  logic                reset,
    input  logic                Zin,
    input  datapathPkg::word_t  yData,
    input  datapathPkg::word_t  busData,
    input  datapathPkg::aluOp_t opcode,
    output datapathPkg::wide_t  result
);

    localparam int CountWidth = $clog2(`DATAPATH_WORD);

    logic [CountWidth-1:0] count;

    logic signed [`DATAPATH_WORD-1:0]   ySigned;
    logic signed [`DATAPATH_WORD-1:0]   bSigned;
    logic signed [2*`DATAPATH_WORD-1:0] yWide;
    logic signed [2*`DATAPATH_WORD-1:0] bWide;

    datapathPkg::wide_t product;
    datapathPkg::wide_t rotRight;
    datapathPkg::wide_t rotLeft;
    datapathPkg::word_t quotient;
    datapathPkg::word_t remainder;
    datapathPkg::word_t shifted;

    // Shift and rotate counts come from the low bits of the bus
    assign count = busData[CountWidth-1:0];

    assign ySigned = yData;
    assign bSigned = busData;
    assign yWide   = ySigned;
    assign bWide   = bSigned;
    assign product = yWide * bWide;

    // Rotates shift a doubled copy so the wrapped bits fall into place
    assign rotRight = {yData, yData} >> count;
    assign rotLeft  = {yData, yData} << count;

    // Zero divisor yields zero rather than an undefined quotient
    always_comb begin
        if (busData == '0) begin
            quotient  = '0;
            remainder = '0;
        end else begin
            quotient  = datapathPkg::word_t'(ySigned / bSigned);
            remainder = datapathPkg::word_t'(ySigned % bSigned);
        end
    end

    always_comb begin
        shifted = '0;
        case (opcode)
            datapathPkg::opAdd:  shifted = yData + busData;
            datapathPkg::opSub:  shifted = yData - busData;
            datapathPkg::opAnd:  shifted = yData & busData;
            datapathPkg::opOr:   shifted = yData | busData;
            datapathPkg::opShr:  shifted = yData >> count;
            datapathPkg::opShra: shifted = datapathPkg::word_t'(ySigned >>> count);
            datapathPkg::opShl:  shifted = yData << count;
            datapathPkg::opRor:  shifted = rotRight[`DATAPATH_WORD-1:0];
            datapathPkg::opRol:  shifted = rotLeft[2*`DATAPATH_WORD-1:`DATAPATH_WORD];
            datapathPkg::opNeg:  shifted = -busData;
            datapathPkg::opNot:  shifted = ~busData;
            default:             shifted = '0;
        endcase
    end

    // Multiply and divide fill both halves, everything else leaves Z high clear
    always_comb begin
        case (opcode)
            datapathPkg::opMul: result = product;
            datapathPkg::opDiv: result = {remainder, quotient};
            default:            result = {{`DATAPATH_WORD{1'b0}}, shifted};
        endcase
    end

    // Control must not capture a divide by zero into Z
    divisorNonZero: assert property (
        @(posedge Clock) disable iff (reset)
        (Zin && opcode == datapathPkg::opDiv) |-> (busData != '0)
    ) else $error("divide captured into Z with a zero divisor");

endmodule

/* src/specialRegisters.sv */
`timescale 1ns/1ps

module specialRegisters (
    input  logic               Clock,
    input  logic               reset,
    input  logic               PCin,
    input  logic               IncPC,
    input  logic               IRin,
    input  logic               MARin,
    input  logic               MDRin,
    input  logic               Read,
    input  logic               Yin,
    input  logic               Zin,
    input  logic               HIin,
    input  logic               LOin,
    input  datapathPkg::word_t busData,
    input  datapathPkg::word_t Mdatain,
    input  datapathPkg::wide_t aluResult,
    output datapathPkg::word_t pcData,
    output datapathPkg::word_t irWord,
    output datapathPkg::word_t marAddress,
    output datapathPkg::word_t mdrData,
    output datapathPkg::word_t yData,
    output datapathPkg::word_t hiData,
    output datapathPkg::word_t loData,
    output datapathPkg::word_t zHigh,
    output datapathPkg::word_t zLow
);

    datapathPkg::word_t pcNext;
    datapathPkg::word_t mdrNext;

    // PC takes the bus value, bumped by one during a fetch
    assign pcNext  = IncPC ? busData + datapathPkg::word_t'(1) : busData;
    // Memory data bypasses the bus on a read
    assign mdrNext = Read ? Mdatain : busData;

    always_ff @(posedge Clock) begin
        if (reset) begin
            pcData     <= '0;
            irWord     <= '0;
            marAddress <= '0;
            mdrData    <= '0;
            yData      <= '0;
            hiData     <= '0;
            loData     <= '0;
            zHigh      <= '0;
            zLow       <= '0;
        end else begin
            if (PCin) begin
                pcData <= pcNext;
            end
            if (IRin) begin
                irWord <= busData;
            end
            if (MARin) begin
                marAddress <= busData;
            end
            if (MDRin) begin
                mdrData <= mdrNext;
            end
            if (Yin) begin
                yData <= busData;
            end
            if (HIin) begin
                hiData <= busData;
            end
            if (LOin) begin
                loData <= busData;
            end
            if (Zin) begin
                {zHigh, zLow} <= aluResult;
            end
        end
    end

endmodule

/* src/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic                  Clock,
    input  logic                  reset,
    input  datapathPkg::regMask_t regIn,
    input  datapathPkg::regMask_t regOut,
    input  logic                  PCin,
    input  logic                  IRin,
    input  logic                  MARin,
    input  logic                  MDRin,
    input  logic                  Yin,
    input  logic                  Zin,
    input  logic                  HIin,
    input  logic                  LOin,
    input  logic                  PCout,
    input  logic                  Zhighout,
    input  logic                  Zlowout,
    input  logic                  MDRout,
    input  logic                  HIout,
    input  logic                  LOout,
    input  logic                  Read,
    input  logic                  IncPC,
    input  datapathPkg::word_t    Mdatain,
    input  datapathPkg::aluOp_t   opcode,
    output datapathPkg::word_t    busData,
    output datapathPkg::word_t    marAddress,
    output datapathPkg::word_t    irWord
);

    datapathPkg::word_t regData;
    logic               regRequest;
    datapathPkg::word_t pcData;
    datapathPkg::word_t mdrData;
    datapathPkg::word_t yData;
    datapathPkg::word_t hiData;
    datapathPkg::word_t loData;
    datapathPkg::word_t zHigh;
    datapathPkg::word_t zLow;
    datapathPkg::wide_t aluResult;

    registerFile u_registerFile (
        .Clock      (Clock),
        .reset      (reset),
        .regIn      (regIn),
        .regOut     (regOut),
        .busData    (busData),
        .regData    (regData),
        .regRequest (regRequest)
    );

    // Grant is only checked inside the arbiter
    busArbiter u_busArbiter (
        .Clock      (Clock),
        .reset      (reset),
        .PCout      (PCout),
        .Zhighout   (Zhighout),
        .Zlowout    (Zlowout),
        .MDRout     (MDRout),
        .HIout      (HIout),
        .LOout      (LOout),
        .regRequest (regRequest),
        .pcData     (pcData),
        .zHigh      (zHigh),
        .zLow       (zLow),
        .mdrData    (mdrData),
        .hiData     (hiData),
        .loData     (loData),
        .regData    (regData),
        .busData    (busData),
        .grant      ()
    );

    alu u_alu (
        .Clock   (Clock),
        .reset   (reset),
        .Zin     (Zin),
        .yData   (yData),
        .busData (busData),
        .opcode  (opcode),
        .result  (aluResult)
    );

    specialRegisters u_specialRegisters (
        .Clock      (Clock),
        .reset      (reset),
        .PCin       (PCin),
        .IncPC      (IncPC),
        .IRin       (IRin),
        .MARin      (MARin),
        .MDRin      (MDRin),
        .Read       (Read),
        .Yin        (Yin),
        .Zin        (Zin),
        .HIin       (HIin),
        .LOin       (LOin),
        .busData    (busData),
        .Mdatain    (Mdatain),
        .aluResult  (aluResult),
        .pcData     (pcData),
        .irWord     (irWord),
        .marAddress (marAddress),
        .mdrData    (mdrData),
        .yData      (yData),
        .hiData     (hiData),
        .loData     (loData),
        .zHigh      (zHigh),
        .zLow       (zLow)
    );

endmodule

/* bench/datapathTb.sv */
`timescale 1ns/1ps

module datapathTb;

    localparam int FieldCount  = 7;
    localparam int MaxSteps    = 64;
    localparam int ClockPeriod = 4;

    logic                  Clock;
    logic                  reset;
    datapathPkg::regMask_t regIn;
    datapathPkg::regMask_t regOut;
    logic                  PCin;
    logic                  IRin;
    logic                  MARin;
    logic                  MDRin;
    logic                  Yin;
    logic                  Zin;
    logic                  HIin;
    logic                  LOin;
    logic                  PCout;
    logic                  Zhighout;
    logic                  Zlowout;
    logic                  MDRout;
    logic                  HIout;
    logic                  LOout;
    logic                  Read;
    logic                  IncPC;
    datapathPkg::word_t    Mdatain;
    datapathPkg::aluOp_t   opcode;
    datapathPkg::word_t    busData;
    datapathPkg::word_t    marAddress;
    datapathPkg::word_t    irWord;

    // Seven words per step, in the column order of the pattern file
    logic [31:0] patternMem [0:FieldCount*MaxSteps-1];
    int          stepCount;
    int          currentStep;
    logic        loaded;

    // IR holds zero from reset until a step loads it from the bus
    datapathPkg::word_t irExpected;

    datapath u_datapath (
        .Clock      (Clock),
        .reset      (reset),
        .regIn      (regIn),
        .regOut     (regOut),
        .PCin       (PCin),
        .IRin       (IRin),
        .MARin      (MARin),
        .MDRin      (MDRin),
        .Yin        (Yin),
        .Zin        (Zin),
        .HIin       (HIin),
        .LOin       (LOin),
        .PCout      (PCout),
        .Zhighout   (Zhighout),
        .Zlowout    (Zlowout),
        .MDRout     (MDRout),
        .HIout      (HIout),
        .LOout      (LOout),
        .Read       (Read),
        .IncPC      (IncPC),
        .Mdatain    (Mdatain),
        .opcode     (opcode),
        .busData    (busData),
        .marAddress (marAddress),
        .irWord     (irWord)
    );

    always #2 Clock = ~Clock;

    // Strobe word bits, low to high
    // PCin IRin MARin MDRin Yin Zin HIin LOin PCout Zhighout Zlowout MDRout HIout LOout Read IncPC
    task automatic driveStrobes(input logic [15:0] strobes);
        PCin     = strobes[0];
        IRin     = strobes[1];
        MARin    = strobes[2];
        MDRin    = strobes[3];
        Yin      = strobes[4];
        Zin      = strobes[5];
        HIin     = strobes[6];
        LOin     = strobes[7];
        PCout    = strobes[8];
        Zhighout = strobes[9];
        Zlowout  = strobes[10];
        MDRout   = strobes[11];
        HIout    = strobes[12];
        LOout    = strobes[13];
        Read     = strobes[14];
        IncPC    = strobes[15];
    endtask

    task automatic applyStep(input int step);
        int base;
        base = step * FieldCount;
        driveStrobes(patternMem[base][15:0]);
        regIn   = patternMem[base+1][15:0];
        regOut  = patternMem[base+2][15:0];
        Mdatain = patternMem[base+3];
        opcode  = datapathPkg::aluOp_t'(patternMem[base+4][4:0]);
    endtask

    task automatic checkBus(input datapathPkg::word_t expected);
        if (busData !== expected) begin
            $display("FAIL busData at step %0d expected %h actual %h",
                     currentStep, expected, busData);
            $display("*** FAILED ***");
            $fatal(1, "busData mismatch");
        end
    endtask

    task automatic checkAddress(input datapathPkg::word_t expected);
        if (marAddress !== expected) begin
            $display("FAIL marAddress at step %0d expected %h actual %h",
                     currentStep, expected, marAddress);
            $display("*** FAILED ***");
            $fatal(1, "marAddress mismatch");
        end
    endtask

    task automatic checkInstruction(input datapathPkg::word_t expected);
        if (irWord !== expected) begin
            $display("FAIL irWord at step %0d expected %h actual %h",
                     currentStep, expected, irWord);
            $display("*** FAILED ***");
            $fatal(1, "irWord mismatch");
        end
    endtask

    // Check kind 0 skips, 1 compares the bus, 2 compares MAR
    task automatic checkStep(input int step);
        int base;
        base = step * FieldCount;
        case (patternMem[base+5])
            32'd0: begin
            end
            32'd1: checkBus(patternMem[base+6]);
            32'd2: checkAddress(patternMem[base+6]);
            default: begin
                $display("Pattern step %0d has an unknown check kind", step);
                $display("*** FAILED ***");
                $fatal(1, "bad pattern file");
            end
        endcase
    endtask

    // IR takes the bus word, so a step that loads IR must also check the bus
    task automatic trackInstruction(input int step);
        int base;
        base = step * FieldCount;
        if (patternMem[base][1]) begin
            if (patternMem[base+5] != 32'd1) begin
                $display("Pattern step %0d loads IR without a bus check", step);
                $display("*** FAILED ***");
                $fatal(1, "bad pattern file");
            end
            irExpected = patternMem[base+6];
        end
    endtask

    initial begin
        Clock       = 1'b0;
        reset       = 1'b1;
        loaded      = 1'b0;
        currentStep = 0;
        irExpected  = '0;
        driveStrobes(16'h0000);
        regIn   = '0;
        regOut  = '0;
        Mdatain = '0;
        opcode  = datapathPkg::opAdd;

        // Upper half set marks a word that the file never wrote
        for (int i = 0; i < FieldCount * MaxSteps; i++) begin
            patternMem[i] = 32'hffff_0000 | 32'(i);
        end
        $readmemh("bench/datapath_patterns.txt", patternMem);
        stepCount = 0;
        while (stepCount < MaxSteps && patternMem[stepCount*FieldCount][31:16] == 16'h0000) begin
            stepCount++;
        end
        if (stepCount == 0) begin
            $display("The pattern file holds no steps");
            $display("*** FAILED ***");
            $fatal(1, "empty pattern file");
        end
        loaded = 1'b1;

        repeat (2) @(posedge Clock);
        #1;
        reset = 1'b0;
        for (int step = 0; step < stepCount; step++) begin
            currentStep = step;
            applyStep(step);
            #2;
            checkStep(step);
            checkInstruction(irExpected);
            trackInstruction(step);
            @(posedge Clock);
            #1;
        end
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        wait (loaded);
        #(stepCount * ClockPeriod + 100);
        $display("Timeout: the pattern replay did not finish in time");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

/* bench/datapath_patterns.txt */
// strobe regIn regOut Mdatain opcode check expected
// check 0 none, 1 busData, 2 marAddress; strobe bit order is in bench/datapathTb.sv
// Every source reads zero after reset
0100 0000 0000 00000000 00 1 00000000
0200 0000 0000 00000000 00 1 00000000
0400 0000 0000 00000000 00 1 00000000
0800 0000 0000 00000000 00 1 00000000
1000 0000 0000 00000000 00 1 00000000
2000 0000 0000 00000000 00 1 00000000
0000 0000 ffff 00000000 00 1 00000000
0000 0000 0000 00000000 00 2 00000000
// Memory loads into R6 and R4
4008 0000 0000 00000018 00 0 00000000
0800 0040 0000 00000000 00 1 00000018
4008 0000 0000 00000014 00 0 00000000
0800 0010 0000 00000000 00 1 00000014
0000 0000 0040 00000000 00 1 00000018
// Y from R6, then R4 into the ALU and Z read back
0010 0000 0040 00000000 00 1 00000018
0020 0000 0010 00000000 03 1 00000014
0400 0000 0000 00000000 00 1 0000002c
0020 0000 0010 00000000 04 1 00000014
0400 0000 0000 00000000 00 1 00000004
0020 0000 0010 00000000 05 1 00000014
0400 0000 0000 00000000 00 1 00000010
0020 0000 0010 00000000 06 1 00000014
0400 0000 0000 00000000 00 1 0000001c
0020 0000 0010 00000000 07 1 00000014
0400 0000 0000 00000000 00 1 00000000
0020 0000 0010 00000000 08 1 00000014
0400 0000 0000 00000000 00 1 00000000
0020 0000 0010 00000000 09 1 00000014
0400 0000 0000 00000000 00 1 01800000
0020 0000 0010 00000000 0a 1 00000014
0400 0000 0000 00000000 00 1 00018000
0020 0000 0010 00000000 0b 1 00000014
0400 0000 0000 00000000 00 1 01800000
0020 0000 0010 00000000 0f 1 00000014
0400 0000 0000 00000000 00 1 000001e0
0200 0000 0000 00000000 00 1 00000000
0020 0000 0010 00000000 10 1 00000014
0400 0000 0000 00000000 00 1 00000001
0200 0000 0000 00000000 00 1 00000004
0020 0000 0010 00000000 11 1 00000014
0400 0000 0000 00000000 00 1 ffffffec
0020 0000 0010 00000000 12 1 00000014
0400 0000 0000 00000000 00 1 ffffffeb
// Fetch from 0x100
4008 0000 0000 00000100 00 0 00000000
0801 0000 0000 00000000 00 1 00000100
8105 0000 0000 00000000 00 1 00000100
0100 0000 0000 00000000 00 1 00000101
0000 0000 0000 00000000 00 2 00000100
// MDR beats a register, R4 beats R6
0800 0000 0040 00000000 00 1 00000100
0000 0000 0050 00000000 00 1 00000014

/* tb.f */
+incdir+include
src/datapathPkg.sv
src/registerFile.sv
src/busArbiter.sv
src/alu.sv
src/specialRegisters.sv
src/datapath.sv
bench/datapathTb.sv

/* Makefile */
SOURCES := $(shell grep -v '^+' tb.f) include/datapath_macros.svh

.PHONY: all run clean

all: obj_dir/VdatapathTb

obj_dir/VdatapathTb: tb.f $(SOURCES)
	verilator --binary --assert --top-module datapathTb -f tb.f

run: obj_dir/VdatapathTb
	./obj_dir/VdatapathTb | grep -F '*** PASSED ***'

clean:
	rm -rf obj_dir
